//--- build.f
src/usb_xact_pkg.sv
src/bulk_xact_fsm.sv
src/turnaround_timer.sv
src/tx_path.sv
src/rx_path.sv
src/usb_bulk_transactor.sv
verif/tb_usb_bulk_transactor.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the bulk transactor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
  --top-module tb_usb_bulk_transactor --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0

//--- verif/tb_usb_bulk_transactor.sv
`timescale 1ns/1ps
module tb_usb_bulk_transactor
  import usb_xact_pkg::*;
();

  localparam usb_addr_t DEV_ADDR  = 7'h2a;
  // Tests take about 230 cycles
  localparam int        MAX_CYCLES = 500;

  logic clock, reset, tok_recv_i, hsk_recv_i, rx_valid_i, eop_recv_i;
  logic tx_ready_i, usb_sent_i, hsk_sent_i, blk_in_valid_i, blk_in_ready_i;
  logic blk_out_ready_i, cfg_reset_i;
  logic rx_ready_o, tx_valid_o, hsk_send_o, blk_in_ready_o, blk_out_valid_o, timeout_error_o;
  usb_addr_t usb_addr_i;
  token_t    tok_i;
  usb_pid_t  hsk_pid_i, rx_pid_i, tx_pid_o, hsk_pid_o;
  beat_t     rx_beat_i, blk_in_beat_i, tx_beat_o, blk_out_beat_o;

  int          value_errors = 0;
  int          other_errors = 0;
  int          cycles = 0;
  logic [31:0] lcg_state = 32'h68fa_dbd6;
  // Reference toggles, kept from the USB data toggle rules
  logic        exp_in_tog = 1'b0;
  logic        exp_out_tog = 1'b0;

  usb_bulk_transactor #(.TURNAROUND_CYCLES(20)) dut_i (.*);

  always #20 clock = ~clock;

  // Watchdog
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Handshake request stays up until the encoder reports it sent
  assert property (@(posedge clock) disable iff (reset)
      hsk_send_o && !hsk_sent_i |=> hsk_send_o)
    else begin
      other_errors++;
      $display("Handshake request dropped at time %0t before the encoder sent it", $time);
    end

  // Encoder back-pressure holds the offered beat
  assert property (@(posedge clock) disable iff (reset)
      tx_valid_o && !tx_ready_i |=> tx_valid_o && (tx_beat_o == $past(tx_beat_o)))
    else begin
      other_errors++;
      $display("Transmit beat withdrawn or changed at time %0t while the encoder stalled",
               $time);
    end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act)
      else begin
        value_errors++;
        $display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      end
  endtask

  task automatic send_token(input usb_pid_t pid, input usb_addr_t addr, input usb_endp_t endp);
    @(negedge clock);
    tok_recv_i = 1'b1;
    tok_i      = '{pid: pid, addr: addr, endp: endp};
    @(negedge clock);
    tok_recv_i = 1'b0;
  endtask

  task automatic run_in(input int n, input logic src_ready, input logic host_ack);
    beat_t       exp_q[$];
    beat_t       b;
    int          idx;
    logic [31:0] r;
    usb_pid_t    pid;
    pid = exp_in_tog ? PID_DATA1 : PID_DATA0;
    for (int i = 0; i < n; i++) begin
      r = lcg_next();
      b = '{data: r[15:8], keep: 1'b1, last: (i == n - 1)};
      exp_q.push_back(b);
    end
    @(negedge clock);
    blk_in_ready_i = src_ready;
    // Encoder stalled so the first beat waits for the checks
    tx_ready_i     = 1'b0;
    send_token(PID_IN, DEV_ADDR, 4'd1);
    idx = 0;
    if (src_ready) begin
      while (idx < n) begin
        @(negedge clock);
        r = lcg_next();
        blk_in_valid_i = 1'b1;
        blk_in_beat_i  = exp_q[idx];
        tx_ready_i     = (r[2:0] != 3'd0);
        #5;
        check_eq("tx_valid_o", 1, tx_valid_o);
        check_eq("tx_beat_o", exp_q[idx], tx_beat_o);
        check_eq("tx_pid_o", pid, tx_pid_o);
        check_eq("blk_in_ready_o", tx_ready_i, blk_in_ready_o);
        if (tx_ready_i) idx++;
      end
    end else begin
      // One empty beat, offered until the encoder takes it
      while (idx == 0) begin
        @(negedge clock);
        r = lcg_next();
        tx_ready_i = r[0];
        #5;
        check_eq("tx_valid_o", 1, tx_valid_o);
        check_eq("tx_beat_o.keep", 0, tx_beat_o.keep);
        check_eq("tx_beat_o.last", 1, tx_beat_o.last);
        check_eq("tx_pid_o", pid, tx_pid_o);
        if (tx_ready_i) idx++;
      end
      @(negedge clock);
      tx_ready_i = 1'b1;
      #5;
      check_eq("tx_valid_o", 0, tx_valid_o);
    end
    @(negedge clock);
    blk_in_valid_i = 1'b0;
    usb_sent_i     = 1'b1;
    @(negedge clock);
    usb_sent_i = 1'b0;
    if (host_ack) begin
      hsk_recv_i = 1'b1;
      hsk_pid_i  = PID_ACK;
      exp_in_tog = ~exp_in_tog;
      @(negedge clock);
      hsk_recv_i = 1'b0;
    end else begin
      // Load edge is behind us, the flag must rise on edge 21
      for (int k = 1; k <= 21; k++) begin
        @(negedge clock);
        #5;
        check_eq("timeout_error_o", (k == 21), timeout_error_o);
      end
    end
    repeat (2) @(negedge clock);
  endtask

  task automatic run_out(input int n, input logic sink_ready, input usb_pid_t pid);
    logic        fwd;
    logic        first;
    int          idx;
    logic [31:0] r;
    beat_t       b;
    fwd = sink_ready && (pid == (exp_out_tog ? PID_DATA1 : PID_DATA0));
    @(negedge clock);
    blk_out_ready_i = sink_ready;
    send_token(PID_OUT, DEV_ADDR, 4'd2);
    idx   = 0;
    first = 1'b1;
    while (idx < n) begin
      @(negedge clock);
      r = lcg_next();
      b = '{data: r[23:16], keep: 1'b1, last: (idx == n - 1)};
      rx_valid_i = 1'b1;
      rx_beat_i  = b;
      rx_pid_i   = pid;
      // The sink stalls on the first beat and now and then afterwards
      if (sink_ready) blk_out_ready_i = !first && (r[1:0] != 2'd0);
      first = 1'b0;
      #5;
      if (fwd) begin
        check_eq("blk_out_valid_o", 1, blk_out_valid_o);
        check_eq("blk_out_beat_o", b, blk_out_beat_o);
        check_eq("rx_ready_o", blk_out_ready_i, rx_ready_o);
        if (blk_out_ready_i) idx++;
      end else begin
        check_eq("blk_out_valid_o", 0, blk_out_valid_o);
        check_eq("rx_ready_o", 1, rx_ready_o);
        idx++;
      end
    end
    @(negedge clock);
    rx_valid_i      = 1'b0;
    eop_recv_i      = 1'b1;
    blk_out_ready_i = sink_ready;
    if (fwd) exp_out_tog = ~exp_out_tog;
    @(negedge clock);
    eop_recv_i = 1'b0;
    #5;
    check_eq("hsk_send_o", 1, hsk_send_o);
    check_eq("hsk_pid_o", sink_ready ? PID_ACK : PID_NAK, hsk_pid_o);
    @(negedge clock);
    hsk_sent_i = 1'b1;
    @(negedge clock);
    hsk_sent_i = 1'b0;
    #5;
    check_eq("hsk_send_o", 0, hsk_send_o);
    @(negedge clock);
  endtask

  task automatic check_ignored(input usb_pid_t pid, input usb_addr_t addr, input usb_endp_t endp);
    @(negedge clock);
    // Source and sink both ready, so an accepted token would show at once
    blk_in_ready_i  = 1'b1;
    blk_in_valid_i  = 1'b1;
    blk_out_ready_i = 1'b1;
    send_token(pid, addr, endp);
    repeat (4) begin
      @(negedge clock);
      #5;
      check_eq("tx_valid_o", 0, tx_valid_o);
      check_eq("rx_ready_o", 0, rx_ready_o);
      check_eq("hsk_send_o", 0, hsk_send_o);
    end
    blk_in_valid_i = 1'b0;
  endtask

  initial begin
    clock           = 1'b0;
    reset           = 1'b1;
    usb_addr_i      = DEV_ADDR;
    tok_recv_i      = 1'b0;
    tok_i           = '0;
    hsk_recv_i      = 1'b0;
    hsk_pid_i       = '0;
    rx_valid_i      = 1'b0;
    rx_beat_i       = '0;
    rx_pid_i        = '0;
    eop_recv_i      = 1'b0;
    tx_ready_i      = 1'b1;
    usb_sent_i      = 1'b0;
    hsk_sent_i      = 1'b0;
    blk_in_valid_i  = 1'b0;
    blk_in_beat_i   = '0;
    blk_in_ready_i  = 1'b0;
    blk_out_ready_i = 1'b0;
    cfg_reset_i     = 1'b0;
    repeat (8) @(negedge clock);
    reset = 1'b0;
    #5;
    check_eq("tx_valid_o", 0, tx_valid_o);
    check_eq("rx_ready_o", 0, rx_ready_o);
    check_eq("hsk_send_o", 0, hsk_send_o);
    check_eq("timeout_error_o", 0, timeout_error_o);
    check_eq("tx_pid_o", PID_DATA0, tx_pid_o);

    run_in(6, 1'b1, 1'b1);
    run_in(5, 1'b1, 1'b1);
    run_in(3, 1'b1, 1'b0);
    run_in(3, 1'b1, 1'b1);
    run_in(0, 1'b0, 1'b1);

    run_out(5, 1'b1, PID_DATA0);
    run_out(5, 1'b1, PID_DATA0);
    run_out(4, 1'b1, PID_DATA1);
    run_out(4, 1'b0, PID_DATA0);

    check_ignored(PID_IN, DEV_ADDR + 7'd1, 4'd1);
    check_ignored(PID_IN, DEV_ADDR, 4'd2);
    check_ignored(PID_OUT, DEV_ADDR, 4'd1);
    check_ignored(PID_SOF, DEV_ADDR, 4'd1);

    // Both toggles on DATA1 before the configuration event
    run_in(2, 1'b1, 1'b1);
    run_out(3, 1'b1, PID_DATA0);
    @(negedge clock);
    cfg_reset_i = 1'b1;
    exp_in_tog  = 1'b0;
    exp_out_tog = 1'b0;
    @(negedge clock);
    cfg_reset_i = 1'b0;
    run_in(4, 1'b1, 1'b1);
    run_out(4, 1'b1, PID_DATA0);

    $display("Error counts: value=%0d other=%0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- src/usb_bulk_transactor.sv
`timescale 1ns/1ps
module usb_bulk_transactor
  import usb_xact_pkg::*;
#(
  parameter usb_endp_t BULK_IN_EP        = 4'd1,
  parameter usb_endp_t BULK_OUT_EP       = 4'd2,
  parameter int        TURNAROUND_CYCLES = 255
) (
  input  logic      clock,
  input  logic      reset,
  input  usb_addr_t usb_addr_i,

  // From the packet decoder
  input  logic      tok_recv_i,
  input  token_t    tok_i,
  input  logic      hsk_recv_i,
  input  usb_pid_t  hsk_pid_i,
  input  logic      rx_valid_i,
  input  beat_t     rx_beat_i,
  input  usb_pid_t  rx_pid_i,
  output logic      rx_ready_o,
  input  logic      eop_recv_i,

  // To the packet encoder
  output logic      tx_valid_o,
  output beat_t     tx_beat_o,
  output usb_pid_t  tx_pid_o,
  input  logic      tx_ready_i,
  input  logic      usb_sent_i,
  output logic      hsk_send_o,
  output usb_pid_t  hsk_pid_o,
  input  logic      hsk_sent_i,

  // Bulk source and sink
  input  logic      blk_in_valid_i,
  input  beat_t     blk_in_beat_i,
  output logic      blk_in_ready_o,
  input  logic      blk_in_ready_i,
  output logic      blk_out_valid_o,
  output beat_t     blk_out_beat_o,
  input  logic      blk_out_ready_i,

  input  logic      cfg_reset_i,
  output logic      timeout_error_o
);

  xact_state_t xact_state;

  bulk_xact_fsm #(
    .BULK_IN_EP (BULK_IN_EP),
    .BULK_OUT_EP(BULK_OUT_EP)
  ) fsm_i (
    .clock          (clock),
    .reset          (reset),
    .usb_addr_i     (usb_addr_i),
    .tok_recv_i     (tok_recv_i),
    .tok_i          (tok_i),
    .hsk_recv_i     (hsk_recv_i),
    .eop_recv_i     (eop_recv_i),
    .usb_sent_i     (usb_sent_i),
    .hsk_sent_i     (hsk_sent_i),
    .blk_in_ready_i (blk_in_ready_i),
    .blk_out_ready_i(blk_out_ready_i),
    .timeout_i      (timeout_error_o),
    .xact_state_o   (xact_state),
    .hsk_send_o     (hsk_send_o),
    .hsk_pid_o      (hsk_pid_o)
  );

  turnaround_timer #(
    .TURNAROUND_CYCLES(TURNAROUND_CYCLES)
  ) timer_i (
    .clock          (clock),
    .reset          (reset),
    .usb_sent_i     (usb_sent_i),
    .hsk_sent_i     (hsk_sent_i),
    .tok_recv_i     (tok_recv_i),
    .hsk_recv_i     (hsk_recv_i),
    .eop_recv_i     (eop_recv_i),
    .timeout_error_o(timeout_error_o)
  );

  tx_path tx_path_i (
    .clock         (clock),
    .reset         (reset),
    .xact_state_i  (xact_state),
    .hsk_recv_i    (hsk_recv_i),
    .hsk_pid_i     (hsk_pid_i),
    .cfg_reset_i   (cfg_reset_i),
    .blk_in_valid_i(blk_in_valid_i),
    .blk_in_beat_i (blk_in_beat_i),
    .blk_in_ready_o(blk_in_ready_o),
    .tx_valid_o    (tx_valid_o),
    .tx_beat_o     (tx_beat_o),
    .tx_pid_o      (tx_pid_o),
    .tx_ready_i    (tx_ready_i)
  );

  rx_path rx_path_i (
    .clock          (clock),
    .reset          (reset),
    .xact_state_i   (xact_state),
    .eop_recv_i     (eop_recv_i),
    .cfg_reset_i    (cfg_reset_i),
    .rx_valid_i     (rx_valid_i),
    .rx_beat_i      (rx_beat_i),
    .rx_pid_i       (rx_pid_i),
    .rx_ready_o     (rx_ready_o),
    .blk_out_valid_o(blk_out_valid_o),
    .blk_out_beat_o (blk_out_beat_o),
    .blk_out_ready_i(blk_out_ready_i)
  );

endmodule

//--- src/rx_path.sv
`timescale 1ns/1ps
module rx_path
  import usb_xact_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  xact_state_t xact_state_i,

  input  logic        eop_recv_i,
  input  logic        cfg_reset_i,

  // Decoder
  input  logic        rx_valid_i,
  input  beat_t       rx_beat_i,
  input  usb_pid_t    rx_pid_i,
  output logic        rx_ready_o,

  // Bulk sink
  output logic        blk_out_valid_o,
  output beat_t       blk_out_beat_o,
  input  logic        blk_out_ready_i
);

  logic     out_tog_q;
  usb_pid_t exp_pid;
  logic     pid_match;

  assign exp_pid   = out_tog_q ? PID_DATA1 : PID_DATA0;
  assign pid_match = (rx_pid_i == exp_pid);

  always_comb begin
    blk_out_valid_o = 1'b0;
    rx_ready_o      = 1'b0;
    case (xact_state_i)
      X_OUT_RX: begin
        // Wrong PID means a retry of data the sink already has
        blk_out_valid_o = rx_valid_i && pid_match;
        rx_ready_o      = pid_match ? blk_out_ready_i : 1'b1;
      end
      X_OUT_DROP: begin
        // Refused packet is drained and thrown away
        rx_ready_o = 1'b1;
      end
      default: begin
        rx_ready_o = 1'b0;
      end
    endcase
  end

  assign blk_out_beat_o = rx_beat_i;

  always_ff @(posedge clock) begin
    if (reset || cfg_reset_i) begin
      out_tog_q <= 1'b0;
    end else if (eop_recv_i && xact_state_i == X_OUT_RX && pid_match) begin
      out_tog_q <= ~out_tog_q;
    end
  end

endmodule

//--- src/tx_path.sv
`timescale 1ns/1ps
module tx_path
  import usb_xact_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  xact_state_t xact_state_i,

  input  logic        hsk_recv_i,
  input  usb_pid_t    hsk_pid_i,
  input  logic        cfg_reset_i,

  // Bulk source
  input  logic        blk_in_valid_i,
  input  beat_t       blk_in_beat_i,
  output logic        blk_in_ready_o,

  // Encoder
  output logic        tx_valid_o,
  output beat_t       tx_beat_o,
  output usb_pid_t    tx_pid_o,
  input  logic        tx_ready_i
);

  // Empty packet is one beat with no real byte
  localparam beat_t ZDP_BEAT = '{data: 8'h00, keep: 1'b0, last: 1'b1};

  logic in_tog_q;
  logic zdp_sent_q;
  logic host_ack;

  assign host_ack = hsk_recv_i && (hsk_pid_i == PID_ACK) && (xact_state_i == X_IN_WAIT);

  always_comb begin
    tx_valid_o     = 1'b0;
    tx_beat_o      = blk_in_beat_i;
    blk_in_ready_o = 1'b0;
    case (xact_state_i)
      X_IN_TX: begin
        tx_valid_o     = blk_in_valid_i;
        blk_in_ready_o = tx_ready_i;
      end
      X_IN_ZDP: begin
        // Offered until the encoder takes it, then never again
        tx_valid_o = !zdp_sent_q;
        tx_beat_o  = ZDP_BEAT;
      end
      default: begin
        tx_valid_o = 1'b0;
      end
    endcase
  end

  // ZDP tracking rearms whenever the FSM leaves the ZDP state
  always_ff @(posedge clock) begin
    if (reset || xact_state_i != X_IN_ZDP) begin
      zdp_sent_q <= 1'b0;
    end else if (tx_valid_o && tx_ready_i) begin
      zdp_sent_q <= 1'b1;
    end
  end

  // IN toggle advances only once the host has acknowledged
  always_ff @(posedge clock) begin
    if (reset || cfg_reset_i) begin
      in_tog_q <= 1'b0;
    end else if (host_ack) begin
      in_tog_q <= ~in_tog_q;
    end
  end

  assign tx_pid_o = in_tog_q ? PID_DATA1 : PID_DATA0;

endmodule

//--- src/turnaround_timer.sv
`timescale 1ns/1ps
module turnaround_timer #(
  parameter int TURNAROUND_CYCLES = 255
) (
  input  logic clock,
  input  logic reset,
  input  logic usb_sent_i,
  input  logic hsk_sent_i,
  input  logic tok_recv_i,
  input  logic hsk_recv_i,
  input  logic eop_recv_i,
  output logic timeout_error_o
);

  localparam int CW = $clog2(TURNAROUND_CYCLES + 1);

  typedef logic [CW-1:0] tcount_t;

  tcount_t       count_q;
  logic [CW:0]   count_next;
  logic          active_q;
  logic          load;
  logic          recv;

  // Device has just put a packet on the bus
  assign load = usb_sent_i || hsk_sent_i;
  // Anything from the host ends the wait
  assign recv = tok_recv_i || hsk_recv_i || eop_recv_i;

  // Extra top bit flags the underflow past zero
  assign count_next = {1'b0, count_q} - (CW + 1)'(1);

  always_ff @(posedge clock) begin
    if (load) begin
      count_q <= tcount_t'(TURNAROUND_CYCLES);
    end else if (active_q) begin
      count_q <= count_next[CW-1:0];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      active_q        <= 1'b0;
      timeout_error_o <= 1'b0;
    end else if (load) begin
      active_q        <= 1'b1;
      timeout_error_o <= 1'b0;
    end else if (recv) begin
      active_q        <= 1'b0;
      timeout_error_o <= 1'b0;
    end else if (active_q && count_next[CW]) begin
      active_q        <= 1'b0;
      timeout_error_o <= 1'b1;
    end
  end

endmodule

//--- src/bulk_xact_fsm.sv
`timescale 1ns/1ps
module bulk_xact_fsm
  import usb_xact_pkg::*;
#(
  parameter usb_endp_t BULK_IN_EP  = 4'd1,
  parameter usb_endp_t BULK_OUT_EP = 4'd2
) (
  input  logic        clock,
  input  logic        reset,
  input  usb_addr_t   usb_addr_i,

  input  logic        tok_recv_i,
  input  token_t      tok_i,
  input  logic        hsk_recv_i,
  input  logic        eop_recv_i,
  input  logic        usb_sent_i,
  input  logic        hsk_sent_i,

  input  logic        blk_in_ready_i,
  input  logic        blk_out_ready_i,
  input  logic        timeout_i,

  output xact_state_t xact_state_o,
  output logic        hsk_send_o,
  output usb_pid_t    hsk_pid_o
);

  xact_state_t state_q;
  xact_state_t state_d;

  logic tok_match;
  logic in_tok;
  logic out_tok;

  // Only tokens to our address and to one of the two bulk endpoints count
  assign tok_match = tok_recv_i && (tok_i.addr == usb_addr_i);
  assign in_tok    = tok_match && (tok_i.pid == PID_IN) && (tok_i.endp == BULK_IN_EP);
  assign out_tok   = tok_match && (tok_i.pid == PID_OUT) && (tok_i.endp == BULK_OUT_EP);

  always_comb begin
    state_d = state_q;
    case (state_q)
      X_IDLE: begin
        if (in_tok) begin
          // A ZDP keeps the host polling when no packet is ready
          state_d = blk_in_ready_i ? X_IN_TX : X_IN_ZDP;
        end else if (out_tok) begin
          state_d = blk_out_ready_i ? X_OUT_RX : X_OUT_DROP;
        end
      end

      X_IN_TX, X_IN_ZDP: begin
        if (usb_sent_i) begin
          state_d = X_IN_WAIT;
        end
      end

      X_IN_WAIT: begin
        // Host answers with a handshake, or it never answers at all
        if (hsk_recv_i || timeout_i) begin
          state_d = X_DONE;
        end
      end

      X_OUT_RX: begin
        if (eop_recv_i) begin
          state_d = X_OUT_ACK;
        end
      end

      X_OUT_DROP: begin
        if (eop_recv_i) begin
          state_d = X_OUT_NAK;
        end
      end

      X_OUT_ACK, X_OUT_NAK: begin
        if (hsk_sent_i) begin
          state_d = X_DONE;
        end
      end

      X_DONE: begin
        state_d = X_IDLE;
      end

      default: begin
        state_d = X_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= X_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign xact_state_o = state_q;

  // Handshake request lasts until the encoder reports it sent
  assign hsk_send_o = (state_q == X_OUT_ACK) || (state_q == X_OUT_NAK);
  assign hsk_pid_o  = (state_q == X_OUT_NAK) ? PID_NAK : PID_ACK;

endmodule

//--- src/usb_xact_pkg.sv
package usb_xact_pkg;

  // Widths with a meaning of their own
  typedef logic [7:0] byte_t;
  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;

  // The decoder can deliver codes that are not named below
  typedef logic [3:0] usb_pid_t;

  // Token PIDs
  localparam usb_pid_t PID_OUT   = 4'b0001;
  localparam usb_pid_t PID_IN    = 4'b1001;
  localparam usb_pid_t PID_SOF   = 4'b0101;
  localparam usb_pid_t PID_SETUP = 4'b1101;

  // Data PIDs
  localparam usb_pid_t PID_DATA0 = 4'b0011;
  localparam usb_pid_t PID_DATA1 = 4'b1011;

  // Handshake PIDs
  localparam usb_pid_t PID_ACK   = 4'b0010;
  localparam usb_pid_t PID_NAK   = 4'b1010;

  // One decoded token
  typedef struct packed {
    usb_pid_t  pid;
    usb_addr_t addr;
    usb_endp_t endp;
  } token_t;

  // One stream beat, keep low marks a beat without a real byte
  typedef struct packed {
    byte_t data;
    logic  keep;
    logic  last;
  } beat_t;

  // Bulk transaction states, shared by the FSM and both data paths
  typedef enum logic [3:0] {
    X_IDLE     = 4'd0,
    X_IN_TX    = 4'd1,
    X_IN_ZDP   = 4'd2,
    X_IN_WAIT  = 4'd3,
    X_OUT_RX   = 4'd4,
    X_OUT_DROP = 4'd5,
    X_OUT_ACK  = 4'd6,
    X_OUT_NAK  = 4'd7,
    X_DONE     = 4'd8
  } xact_state_t;

endpackage
